//--- hdl/mem_map_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bases must be word aligned and regions must not overlap.
// Depths are in 32-bit words and should be powers of two.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_MAP_CFG_SVH
`define MEM_MAP_CFG_SVH

// Byte base address of each region
`define MEM_INTERN_BASE   32'h0300_0000
`define MEM_IO_BASE       32'h0400_0000
`define MEM_PALETTE_BASE  32'h0500_0000
`define MEM_VRAM_BASE     32'h0600_0000
`define MEM_OAM_BASE      32'h0700_0000

// Region depths in 32-bit words
`define MEM_INTERN_WORDS  1024
`define MEM_VRAM_WORDS    2048
`define MEM_PALETTE_WORDS 128
`define MEM_OAM_WORDS     256

// I/O window is a compact bank of word registers from MEM_IO_BASE
`define MEM_NUM_IO_REGS   8

// Low half of this register is the live button state
`define MEM_KEYINPUT_IDX  6

// High half of this register is the live scanline count
`define MEM_VCOUNT_IDX    1

`endif

//--- hdl/mem_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus and graphics port types. Data is little endian and already
// aligned to its byte lanes by the requester.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  byte_en_t;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'b00,
        MEM_SIZE_HALF = 2'b01,
        MEM_SIZE_WORD = 2'b10
    } mem_size_e;

    // One CPU/DMA bus request, held while the bus is paused
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        mem_size_e size;
        logic      write;
    } bus_req_t;

    // Graphics side reads, one address per RAM
    typedef struct packed {
        bus_addr_t vram_addr;
        bus_addr_t palette_addr;
        bus_addr_t oam_addr;
    } gfx_req_t;

    typedef struct packed {
        bus_data_t vram_data;
        bus_data_t palette_data;
        bus_data_t oam_data;
    } gfx_rsp_t;

endpackage

`default_nettype wire

//--- hdl/mem_io_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O register bank types, sized from the memory map config.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "mem_map_cfg.svh"

package mem_io_pkg;

    typedef logic [31:0] io_word_t;

    typedef logic [$clog2(`MEM_NUM_IO_REGS)-1:0] io_idx_t;

    // Whole bank as one vector, register i at io_regs[i]
    typedef io_word_t [`MEM_NUM_IO_REGS-1:0] io_regs_t;

endpackage

`default_nettype wire

//--- hdl/mem_byte_lanes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte write enables from access size and address bits 1:0.
// Halfword writes must be halfword aligned.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module mem_byte_lanes
    import mem_bus_pkg::*;
(
    input  logic [1:0] addr_low,
    input  mem_size_e  size,
    input  logic       write,
    output byte_en_t   byte_en
);

    always_comb begin
        byte_en = '0;
        if (write) begin
            case (size)
                MEM_SIZE_BYTE: byte_en[addr_low] = 1'b1;
                // Bit 1 picks the upper or lower halfword
                MEM_SIZE_HALF: byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
                MEM_SIZE_WORD: byte_en = 4'b1111;
                default:       byte_en = '0;
            endcase
        end
    end

    // Halfword writes keep address bit 0 clear
    always_comb begin
        if (write && size == MEM_SIZE_HALF) begin
            assert final (!addr_low[0])
                else $error("halfword write at odd address, low bits %b", addr_low);
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_dp_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inferred dual-port block RAM, contents undefined after power up.
// Port A is write-first, port B returns old data on a collision.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module mem_dp_ram
    import mem_bus_pkg::*;
#(
    parameter int DEPTH = 1024
) (
    input  logic                     clock,

    // Bus side, read and byte write
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  byte_en_t                 a_byte_en,
    input  bus_data_t                a_wdata,
    output bus_data_t                a_rdata,

    // Graphics side, read only
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output bus_data_t                b_rdata
);

    bus_data_t mem [DEPTH];
    bus_data_t a_merged;

    // Word as it will be after this edge's write
    always_comb begin
        a_merged = mem[a_addr];
        for (int b = 0; b < 4; b++) begin
            if (a_byte_en[b]) begin
                a_merged[8*b +: 8] = a_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (a_byte_en != '0) begin
            mem[a_addr] <= a_merged;
        end
        a_rdata <= a_merged;
    end

    always_ff @(posedge clock) begin
        b_rdata <= mem[b_addr];
    end

    a_addr_in_range: assert property (@(posedge clock)
        (a_byte_en != '0) |-> (a_addr < DEPTH));

    b_addr_in_range: assert property (@(posedge clock)
        !$isunknown(b_addr) |-> (b_addr < DEPTH));

endmodule

`default_nettype wire

//--- hdl/mem_io_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-mapped I/O register bank with byte writes.
// KEYINPUT low half and VCOUNT high half follow their inputs and
// ignore writes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

`include "mem_map_cfg.svh"

module mem_io_regs
    import mem_bus_pkg::*;
    import mem_io_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // Write port, byte_en is already zero outside a write
    input  logic        sel,
    input  io_idx_t     idx,
    input  byte_en_t    byte_en,
    input  bus_data_t   wdata,

    // Live values for the read-only halves
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,

    output bus_data_t   rdata,
    output io_regs_t    regs
);

    localparam int KEY_IDX = `MEM_KEYINPUT_IDX;
    localparam int VC_IDX  = `MEM_VCOUNT_IDX;

    logic [31:0] live_bits;

    // buttons land in the low half and vcount in the high half
    assign live_bits = {vcount, buttons};

    for (genvar i = 0; i < `MEM_NUM_IO_REGS; i++) begin : g_reg
        // Bits that come from the live inputs instead of storage
        localparam io_word_t RO_MASK = (i == KEY_IDX) ? 32'h0000_ffff :
                                       (i == VC_IDX)  ? 32'hffff_0000 :
                                                        32'h0000_0000;
        localparam byte_en_t WR_MASK = (i == KEY_IDX) ? 4'b1100 :
                                       (i == VC_IDX)  ? 4'b0011 :
                                                        4'b1111;

        io_word_t value_q;
        byte_en_t we;

        assign we = (sel && idx == io_idx_t'(i)) ? (byte_en & WR_MASK) : '0;

        always_ff @(posedge clock, posedge reset) begin
            if (reset) begin
                value_q <= '0;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (we[b]) begin
                        value_q[8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end

        // Masked bytes are never written, so they stay zero in value_q
        assign regs[i] = value_q | (live_bits & RO_MASK);
    end

    assign rdata = regs[idx];

endmodule

`default_nettype wire

//--- hdl/mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Console memory system. Reads take one cycle, writes pause the bus
// once. Unmapped reads return zero; graphics addresses alias by depth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

`include "mem_map_cfg.svh"

module mem_top
    import mem_bus_pkg::*;
    import mem_io_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // CPU/DMA bus
    input  bus_req_t    bus_req,
    output bus_data_t   bus_rdata,
    output logic        bus_pause,

    // Graphics pipeline, read only
    input  gfx_req_t    gfx_req,
    output gfx_rsp_t    gfx_rsp,

    // Read-only register sources
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,

    output io_regs_t    io_regs
);

    localparam int INTERN_AW  = $clog2(`MEM_INTERN_WORDS);
    localparam int VRAM_AW    = $clog2(`MEM_VRAM_WORDS);
    localparam int PALETTE_AW = $clog2(`MEM_PALETTE_WORDS);
    localparam int OAM_AW     = $clog2(`MEM_OAM_WORDS);
    localparam int IO_AW      = $bits(io_idx_t);

    localparam bus_addr_t INTERN_BYTES  = `MEM_INTERN_WORDS * 4;
    localparam bus_addr_t VRAM_BYTES    = `MEM_VRAM_WORDS * 4;
    localparam bus_addr_t PALETTE_BYTES = `MEM_PALETTE_WORDS * 4;
    localparam bus_addr_t OAM_BYTES     = `MEM_OAM_WORDS * 4;
    localparam bus_addr_t IO_BYTES      = `MEM_NUM_IO_REGS * 4;

    typedef struct packed {
        logic intern;
        logic vram;
        logic palette;
        logic oam;
        logic io;
    } region_t;

    function automatic logic in_region(bus_addr_t addr, bus_addr_t base, bus_addr_t bytes);
        bus_addr_t offset;
        offset = addr - base;
        return offset < bytes;
    endfunction

    bus_req_t  req_q;
    logic      write_now;
    bus_addr_t mem_addr;
    region_t   hit;
    byte_en_t  byte_en;

    bus_addr_t intern_off, vram_off, palette_off, oam_off, io_off;
    bus_addr_t vram_gfx_off, palette_gfx_off, oam_gfx_off;

    bus_data_t intern_rdata, vram_rdata, palette_rdata, oam_rdata, io_rdata;
    bus_data_t vram_gfx_data, palette_gfx_data, oam_gfx_data;

    // A request is taken at each edge where the bus is not paused
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            req_q     <= '0;
            bus_pause <= 1'b0;
        end else begin
            bus_pause <= bus_req.write & ~bus_pause;
            if (!bus_pause) begin
                req_q <= bus_req;
            end
        end
    end

    // The write commits at the end of its pause cycle
    assign write_now = req_q.write & bus_pause;
    assign mem_addr  = bus_pause ? req_q.addr : bus_req.addr;

    // Region of the latched request, used for both write gating and read mux
    always_comb begin
        hit.intern  = in_region(req_q.addr, `MEM_INTERN_BASE, INTERN_BYTES);
        hit.vram    = in_region(req_q.addr, `MEM_VRAM_BASE, VRAM_BYTES);
        hit.palette = in_region(req_q.addr, `MEM_PALETTE_BASE, PALETTE_BYTES);
        hit.oam     = in_region(req_q.addr, `MEM_OAM_BASE, OAM_BYTES);
        hit.io      = in_region(req_q.addr, `MEM_IO_BASE, IO_BYTES);
    end

    mem_byte_lanes lanes_inst (
        .addr_low (req_q.addr[1:0]),
        .size     (req_q.size),
        .write    (write_now),
        .byte_en  (byte_en)
    );

    assign intern_off  = mem_addr - `MEM_INTERN_BASE;
    assign vram_off    = mem_addr - `MEM_VRAM_BASE;
    assign palette_off = mem_addr - `MEM_PALETTE_BASE;
    assign oam_off     = mem_addr - `MEM_OAM_BASE;
    assign io_off      = req_q.addr - `MEM_IO_BASE;

    assign vram_gfx_off    = gfx_req.vram_addr - `MEM_VRAM_BASE;
    assign palette_gfx_off = gfx_req.palette_addr - `MEM_PALETTE_BASE;
    assign oam_gfx_off     = gfx_req.oam_addr - `MEM_OAM_BASE;

    // Work RAM has no graphics reader, its port B sits at word 0
    mem_dp_ram #(.DEPTH(`MEM_INTERN_WORDS)) intern_inst (
        .clock     (clock),
        .a_addr    (intern_off[INTERN_AW+1:2]),
        .a_byte_en (hit.intern ? byte_en : 4'b0000),
        .a_wdata   (req_q.wdata),
        .a_rdata   (intern_rdata),
        .b_addr    ('0),
        .b_rdata   ()
    );

    mem_dp_ram #(.DEPTH(`MEM_VRAM_WORDS)) vram_inst (
        .clock     (clock),
        .a_addr    (vram_off[VRAM_AW+1:2]),
        .a_byte_en (hit.vram ? byte_en : 4'b0000),
        .a_wdata   (req_q.wdata),
        .a_rdata   (vram_rdata),
        .b_addr    (vram_gfx_off[VRAM_AW+1:2]),
        .b_rdata   (vram_gfx_data)
    );

    mem_dp_ram #(.DEPTH(`MEM_PALETTE_WORDS)) palette_inst (
        .clock     (clock),
        .a_addr    (palette_off[PALETTE_AW+1:2]),
        .a_byte_en (hit.palette ? byte_en : 4'b0000),
        .a_wdata   (req_q.wdata),
        .a_rdata   (palette_rdata),
        .b_addr    (palette_gfx_off[PALETTE_AW+1:2]),
        .b_rdata   (palette_gfx_data)
    );

    mem_dp_ram #(.DEPTH(`MEM_OAM_WORDS)) oam_inst (
        .clock     (clock),
        .a_addr    (oam_off[OAM_AW+1:2]),
        .a_byte_en (hit.oam ? byte_en : 4'b0000),
        .a_wdata   (req_q.wdata),
        .a_rdata   (oam_rdata),
        .b_addr    (oam_gfx_off[OAM_AW+1:2]),
        .b_rdata   (oam_gfx_data)
    );

    mem_io_regs io_inst (
        .clock   (clock),
        .reset   (reset),
        .sel     (hit.io),
        .idx     (io_off[IO_AW+1:2]),
        .byte_en (byte_en),
        .wdata   (req_q.wdata),
        .buttons (buttons),
        .vcount  (vcount),
        .rdata   (io_rdata),
        .regs    (io_regs)
    );

    assign gfx_rsp = '{
        vram_data:    vram_gfx_data,
        palette_data: palette_gfx_data,
        oam_data:     oam_gfx_data
    };

    // RAM outputs are already one cycle behind, matching the latched region
    always_comb begin
        if (hit.intern) begin
            bus_rdata = intern_rdata;
        end else if (hit.vram) begin
            bus_rdata = vram_rdata;
        end else if (hit.palette) begin
            bus_rdata = palette_rdata;
        end else if (hit.oam) begin
            bus_rdata = oam_rdata;
        end else if (hit.io) begin
            bus_rdata = io_rdata;
        end else begin
            bus_rdata = '0;
        end
    end

    req_held_in_pause: assert property (@(posedge clock) disable iff (reset)
        bus_pause |-> $stable(bus_req));

    pause_single_cycle: assert property (@(posedge clock) disable iff (reset)
        bus_pause |=> !bus_pause);

endmodule

`default_nettype wire

//--- tests/tb_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Every RAM word is written once before any RAM compare, since RAM has
// no reset. Graphics checks cover VRAM, palette and OAM only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

`include "mem_map_cfg.svh"

module tb_mem_top
    import mem_bus_pkg::*;
    import mem_io_pkg::*;
();

    localparam int R_NONE    = -1;
    localparam int R_INTERN  = 0;
    localparam int R_VRAM    = 1;
    localparam int R_PALETTE = 2;
    localparam int R_OAM     = 3;
    localparam int R_IO      = 4;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_GFX      = 100;
    localparam int NUM_IO       = 40;
    localparam int NUM_UNMAPPED = 30;
    localparam int RAM_WORDS    = `MEM_INTERN_WORDS + `MEM_VRAM_WORDS +
                                  `MEM_PALETTE_WORDS + `MEM_OAM_WORDS;

    // Fill, random pairs, graphics, I/O, unmapped and the final read-back
    localparam int TOTAL_OPS = 1 + RAM_WORDS + NUM_RANDOM * 2 + NUM_GFX * 2 + NUM_IO * 3 + 6 +
                               NUM_UNMAPPED * 2 + RAM_WORDS + `MEM_NUM_IO_REGS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_OPS * 3;

    logic        clock;
    logic        reset;
    bus_req_t    bus_req;
    bus_data_t   bus_rdata;
    logic        bus_pause;
    gfx_req_t    gfx_req;
    gfx_rsp_t    gfx_rsp;
    logic [15:0] buttons;
    logic [15:0] vcount;
    io_regs_t    io_regs;

    // Reference model state
    logic [7:0] intern_bytes [`MEM_INTERN_WORDS*4];
    logic [7:0] vram_bytes [`MEM_VRAM_WORDS*4];
    logic [7:0] palette_bytes [`MEM_PALETTE_WORDS*4];
    logic [7:0] oam_bytes [`MEM_OAM_WORDS*4];
    io_word_t   io_model [`MEM_NUM_IO_REGS];

    logic [31:0] rng_state = 32'hdcb02c15;
    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          test_checks;
    int          test_errors;

    mem_top mem_top_inst (
        .clock     (clock),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .bus_pause (bus_pause),
        .gfx_req   (gfx_req),
        .gfx_rsp   (gfx_rsp),
        .buttons   (buttons),
        .vcount    (vcount),
        .io_regs   (io_regs)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, operations did not complete", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Upper state bits come out in the low half, the LCG low bits repeat quickly
    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    function automatic bus_addr_t region_base(input int r);
        case (r)
            R_INTERN:  return `MEM_INTERN_BASE;
            R_VRAM:    return `MEM_VRAM_BASE;
            R_PALETTE: return `MEM_PALETTE_BASE;
            R_OAM:     return `MEM_OAM_BASE;
            default:   return `MEM_IO_BASE;
        endcase
    endfunction

    function automatic int region_words(input int r);
        case (r)
            R_INTERN:  return `MEM_INTERN_WORDS;
            R_VRAM:    return `MEM_VRAM_WORDS;
            R_PALETTE: return `MEM_PALETTE_WORDS;
            R_OAM:     return `MEM_OAM_WORDS;
            default:   return `MEM_NUM_IO_REGS;
        endcase
    endfunction

    function automatic int region_of(input bus_addr_t addr);
        for (int r = R_INTERN; r <= R_IO; r++) begin
            if (addr >= region_base(r) && addr < region_base(r) + region_words(r) * 4) begin
                return r;
            end
        end
        return R_NONE;
    endfunction

    function automatic logic [7:0] ram_get(input int r, input int off);
        case (r)
            R_INTERN:  return intern_bytes[off];
            R_VRAM:    return vram_bytes[off];
            R_PALETTE: return palette_bytes[off];
            default:   return oam_bytes[off];
        endcase
    endfunction

    task automatic ram_set(input int r, input int off, input logic [7:0] value);
        case (r)
            R_INTERN:  intern_bytes[off] = value;
            R_VRAM:    vram_bytes[off] = value;
            R_PALETTE: palette_bytes[off] = value;
            default:   oam_bytes[off] = value;
        endcase
    endtask

    // Live inputs override the read-only halves
    function automatic io_word_t io_view(input int i);
        io_word_t v;
        v = io_model[i];
        if (i == `MEM_KEYINPUT_IDX) v[15:0] = buttons;
        if (i == `MEM_VCOUNT_IDX) v[31:16] = vcount;
        return v;
    endfunction

    function automatic io_regs_t io_expected();
        io_regs_t e;
        for (int i = 0; i < `MEM_NUM_IO_REGS; i++) begin
            e[i] = io_view(i);
        end
        return e;
    endfunction

    function automatic bus_data_t model_word(input bus_addr_t addr);
        bus_data_t w;
        int        r;
        int        off;
        r = region_of(addr);
        off = int'({addr[31:2], 2'b00} - region_base(r));
        w = '0;
        if (r == R_IO) begin
            w = io_view(off / 4);
        end else if (r != R_NONE) begin
            for (int b = 0; b < 4; b++) begin
                w[8*b +: 8] = ram_get(r, off + b);
            end
        end
        return w;
    endfunction

    task automatic model_write(input bus_addr_t addr, input bus_data_t data, input mem_size_e size);
        logic [3:0] lanes;
        int         r;
        int         off;
        r = region_of(addr);
        off = int'({addr[31:2], 2'b00} - region_base(r));
        if (size == MEM_SIZE_BYTE) lanes = 4'b0001 << addr[1:0];
        else if (size == MEM_SIZE_HALF) lanes = addr[1] ? 4'b1100 : 4'b0011;
        else lanes = 4'b1111;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b] && r == R_IO) io_model[off / 4][8*b +: 8] = data[8*b +: 8];
            else if (lanes[b] && r != R_NONE) ram_set(r, off + b, data[8*b +: 8]);
        end
    endtask

    task automatic check_data(input string name, input bus_data_t expected, input bus_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_pause(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR bus_pause expected %h actual %h", expected, actual);
        end
    endtask

    task automatic check_io(input io_regs_t expected, input io_regs_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR io_regs expected %h actual %h", expected, actual);
        end
    endtask

    // Tasks start and end just after a falling edge
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input mem_size_e size);
        bus_req_t req;
        req.addr = addr;
        req.wdata = data;
        req.size = size;
        req.write = 1'b1;
        while (bus_pause) @(negedge clock);
        @(posedge clock);
        bus_req <= req;
        @(posedge clock);
        @(negedge clock);
        check_pause(1'b1, bus_pause);
        // Drop to a plain read at the end of the pause so the write is not taken twice
        req.addr = {addr[31:2], 2'b00};
        req.write = 1'b0;
        @(posedge clock);
        bus_req <= req;
        @(negedge clock);
        check_pause(1'b0, bus_pause);
        model_write(addr, data, size);
    endtask

    task automatic bus_read(input bus_addr_t addr);
        bus_req_t req;
        req.addr = addr;
        req.wdata = '0;
        req.size = MEM_SIZE_WORD;
        req.write = 1'b0;
        while (bus_pause) @(negedge clock);
        @(posedge clock);
        bus_req <= req;
        @(posedge clock);
        @(negedge clock);
        check_pause(1'b0, bus_pause);
        check_data("bus_rdata", model_word(addr), bus_rdata);
    endtask

    task automatic gfx_read(input int r, input bus_addr_t addr);
        gfx_req_t g;
        g = gfx_req;
        if (r == R_VRAM) g.vram_addr = addr;
        else if (r == R_PALETTE) g.palette_addr = addr;
        else g.oam_addr = addr;
        @(posedge clock);
        gfx_req <= g;
        @(posedge clock);
        @(negedge clock);
        if (r == R_VRAM) check_data("gfx_rsp.vram_data", model_word(addr), gfx_rsp.vram_data);
        else if (r == R_PALETTE)
            check_data("gfx_rsp.palette_data", model_word(addr), gfx_rsp.palette_data);
        else check_data("gfx_rsp.oam_data", model_word(addr), gfx_rsp.oam_data);
    endtask

    function automatic bus_addr_t random_addr(input int r, input mem_size_e size);
        bus_addr_t addr;
        addr = region_base(r) + (next_rand() % region_words(r)) * 4;
        if (size == MEM_SIZE_BYTE) addr[1:0] = 2'(next_rand() % 4);
        else if (size == MEM_SIZE_HALF) addr[1] = 1'(next_rand() % 2);
        return addr;
    endfunction

    // Either low memory or just past the end of a region, I/O bank included
    function automatic bus_addr_t unmapped_addr();
        bus_addr_t addr;
        int        k;
        addr = `MEM_INTERN_BASE;
        while (region_of(addr) != R_NONE) begin
            k = next_rand() % 6;
            if (k == 5) addr = next_rand() & 32'h01ff_fffc;
            else addr = region_base(k) + region_words(k) * 4 + (next_rand() & 32'h0000_fffc);
        end
        return addr;
    endfunction

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    initial begin
        bus_addr_t addr;
        mem_size_e size;
        int        r;
        int        idx;

        reset = 1'b1;
        bus_req = '0;
        gfx_req.vram_addr = `MEM_VRAM_BASE;
        gfx_req.palette_addr = `MEM_PALETTE_BASE;
        gfx_req.oam_addr = `MEM_OAM_BASE;
        buttons = '0;
        vcount = '0;
        for (int i = 0; i < `MEM_NUM_IO_REGS; i++) io_model[i] = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        start_test();
        check_pause(1'b0, bus_pause);
        check_io('0, io_regs);
        check_data("bus_rdata", '0, bus_rdata);
        end_test(1, "reset state");

        start_test();
        // Fill word depends on every address bit
        for (int rr = R_INTERN; rr <= R_OAM; rr++) begin
            for (int w = 0; w < region_words(rr); w++) begin
                addr = region_base(rr) + w * 4;
                bus_write(addr, addr ^ {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^
                          32'h9e37_79b9, MEM_SIZE_WORD);
            end
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = next_rand() % 4;
            size = mem_size_e'(next_rand() % 3);
            addr = random_addr(r, size);
            bus_write(addr, next_rand(), size);
            bus_read({addr[31:2], 2'b00});
        end
        end_test(2, "random RAM writes and reads");

        start_test();
        for (int n = 0; n < NUM_GFX; n++) begin
            r = R_VRAM + next_rand() % 3;
            size = mem_size_e'(next_rand() % 3);
            addr = random_addr(r, size);
            bus_write(addr, next_rand(), size);
            gfx_read(r, {addr[31:2], 2'b00});
        end
        end_test(3, "pause and graphics reads");

        start_test();
        for (int n = 0; n < NUM_IO; n++) begin
            @(posedge clock);
            buttons <= 16'(next_rand());
            vcount <= 16'(next_rand());
            @(negedge clock);
            size = mem_size_e'(next_rand() % 3);
            addr = random_addr(R_IO, size);
            bus_write(addr, next_rand(), size);
            check_io(io_expected(), io_regs);
            bus_read({addr[31:2], 2'b00});
        end
        for (int k = 0; k < 2; k++) begin
            idx = (k == 0) ? `MEM_KEYINPUT_IDX : `MEM_VCOUNT_IDX;
            bus_write(`MEM_IO_BASE + idx * 4, 32'hffff_ffff, MEM_SIZE_WORD);
            check_io(io_expected(), io_regs);
            bus_read(`MEM_IO_BASE + idx * 4);
        end
        @(posedge clock);
        buttons <= 16'h5a3c;
        vcount <= 16'h00a0;
        @(negedge clock);
        check_io(io_expected(), io_regs);
        end_test(4, "I/O registers");

        start_test();
        for (int n = 0; n < NUM_UNMAPPED; n++) begin
            bus_read(unmapped_addr());
            bus_write(unmapped_addr(), next_rand(), MEM_SIZE_WORD);
        end
        for (int rr = R_INTERN; rr <= R_IO; rr++) begin
            for (int w = 0; w < region_words(rr); w++) begin
                bus_read(region_base(rr) + w * 4);
            end
        end
        check_io(io_expected(), io_regs);
        end_test(5, "unmapped accesses and read-back");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/mem_io_pkg.sv
hdl/mem_byte_lanes.sv
hdl/mem_dp_ram.sv
hdl/mem_io_regs.sv
hdl/mem_top.sv
tests/tb_mem_top.sv

//--- Bender.yml
package:
  name: mem_system

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_bus_pkg.sv
      - hdl/mem_io_pkg.sv
      - hdl/mem_byte_lanes.sv
      - hdl/mem_dp_ram.sv
      - hdl/mem_io_regs.sv
      - hdl/mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_mem_top.sv
